/* smem_pkg.sv */
// Sizes are fixed: 1024 words of 4 bytes, 8-bit tags, 16-bit wrapping counters
`default_nettype none

package smem_pkg;

    localparam int WORD_BYTES = 4;
    localparam int WORD_WIDTH = WORD_BYTES * 8;
    localparam int TAG_WIDTH  = 8;

    // Word address, 1024 words in total
    localparam int ADDR_WIDTH = 10;
    localparam int CTR_WIDTH  = 16;

    typedef enum logic [0:0] {
        SMEM_READ  = 1'b0,
        SMEM_WRITE = 1'b1
    } smem_op_e;

    // 55 bits
    typedef struct packed {
        smem_op_e                op;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [WORD_BYTES-1:0]   byteen;
        logic [WORD_WIDTH-1:0]   data;
        logic [TAG_WIDTH-1:0]    tag;
    } smem_req_t;

    // 40 bits
    typedef struct packed {
        logic [WORD_WIDTH-1:0]   data;
        logic [TAG_WIDTH-1:0]    tag;
    } smem_rsp_t;

    // 48 bits
    typedef struct packed {
        logic [CTR_WIDTH-1:0]    reads;
        logic [CTR_WIDTH-1:0]    writes;
        logic [CTR_WIDTH-1:0]    rsp_stalls;
    } smem_perf_t;

endpackage

`default_nettype wire

/* smem_req_xbar.sv */
// NUM_BANKS must be a power of two; bank is chosen by the low word address bits
`timescale 1ns/1ps
`default_nettype none

module smem_req_xbar #(
    parameter int NUM_REQS  = 2,
    parameter int NUM_BANKS = 2
) (
    input  wire logic                                        clk,
    input  wire logic                                        reset,

    input  wire logic [NUM_REQS-1:0]                         req_valid,
    input  wire smem_pkg::smem_req_t [NUM_REQS-1:0]          req,
    output logic [NUM_REQS-1:0]                              req_ready,

    output logic [NUM_BANKS-1:0]                             bank_req_valid,
    output smem_pkg::smem_req_t [NUM_BANKS-1:0]              bank_req,
    output logic [NUM_BANKS-1:0][((NUM_REQS > 1) ? $clog2(NUM_REQS) : 1)-1:0] bank_req_idx,
    input  wire logic [NUM_BANKS-1:0]                        bank_req_ready
);

    localparam int REQ_SEL_W  = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1;
    localparam int BANK_SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    logic [NUM_REQS-1:0][BANK_SEL_W-1:0]  req_bank;
    logic [NUM_BANKS-1:0][REQ_SEL_W-1:0]  rr_ptr;
    logic [NUM_BANKS-1:0][REQ_SEL_W-1:0]  win_idx;
    logic [NUM_BANKS-1:0]                 win_found;
    logic [NUM_BANKS-1:0]                 slot_open;

    // Masking keeps the single-bank case at index zero
    always_comb begin
        for (int i = 0; i < NUM_REQS; i++) begin
            req_bank[i] = BANK_SEL_W'(req[i].addr) & BANK_SEL_W'(NUM_BANKS - 1);
        end
    end

    assign slot_open = ~bank_req_valid | bank_req_ready;

    // Round-robin search starting at each bank's pointer
    always_comb begin
        int cand;
        for (int b = 0; b < NUM_BANKS; b++) begin
            win_found[b] = 1'b0;
            win_idx[b]   = '0;
            for (int k = 0; k < NUM_REQS; k++) begin
                cand = (int'(rr_ptr[b]) + k) % NUM_REQS;
                if (!win_found[b] && req_valid[cand]
                        && req_bank[cand] == BANK_SEL_W'(b)) begin
                    win_found[b] = 1'b1;
                    win_idx[b]   = REQ_SEL_W'(cand);
                end
            end
        end
    end

    // A requester targets one bank, so at most one grant reaches it
    always_comb begin
        for (int i = 0; i < NUM_REQS; i++) begin
            req_ready[i] = 1'b0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (win_found[b] && slot_open[b] && int'(win_idx[b]) == i) begin
                    req_ready[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_req_valid <= '0;
            rr_ptr         <= '0;
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (slot_open[b]) begin
                    bank_req_valid[b] <= win_found[b];
                    if (win_found[b]) begin
                        rr_ptr[b] <= (int'(win_idx[b]) == NUM_REQS - 1) ? '0
                                                                       : win_idx[b] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (slot_open[b] && win_found[b]) begin
                bank_req[b]     <= req[win_idx[b]];
                bank_req_idx[b] <= win_idx[b];
            end
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_chk
        // Held slot keeps its request until the bank takes it
        a_slot_hold: assert property (@(posedge clk) disable iff (reset)
            bank_req_valid[b] && !bank_req_ready[b]
            |=> bank_req_valid[b] && $stable(bank_req[b]) && $stable(bank_req_idx[b]));
    end

endmodule

`default_nettype wire

/* smem_bank.sv */
// One bank of 1024/NUM_BANKS words; writes never respond, reads answer one cycle later
`timescale 1ns/1ps
`default_nettype none

module smem_bank #(
    parameter int NUM_REQS  = 2,
    parameter int NUM_BANKS = 2
) (
    input  wire logic                                              clk,
    input  wire logic                                              reset,

    input  wire logic                                              bank_req_valid,
    input  wire smem_pkg::smem_req_t                               bank_req,
    input  wire logic [((NUM_REQS > 1) ? $clog2(NUM_REQS) : 1)-1:0] bank_req_idx,
    output logic                                                   bank_req_ready,

    output logic                                                   bank_rsp_valid,
    output smem_pkg::smem_rsp_t                                    bank_rsp,
    output logic [((NUM_REQS > 1) ? $clog2(NUM_REQS) : 1)-1:0]      bank_rsp_idx,
    input  wire logic                                              bank_rsp_ready
);

    localparam int WORDS_PER_BANK = (1 << smem_pkg::ADDR_WIDTH) / NUM_BANKS;
    localparam int BANK_ADDR_W    = $clog2(WORDS_PER_BANK);
    localparam int BANK_BITS      = $clog2(NUM_BANKS);
    localparam int WB             = smem_pkg::WORD_BYTES;

    logic [smem_pkg::WORD_WIDTH-1:0] mem [WORDS_PER_BANK];

    logic [BANK_ADDR_W-1:0] word_addr;
    logic                   is_read;
    logic                   slot_open;
    logic                   rd_fire;
    logic                   wr_fire;

    // Low bits picked the bank, the rest index the word
    assign word_addr = BANK_ADDR_W'(bank_req.addr >> BANK_BITS);
    assign is_read   = (bank_req.op == smem_pkg::SMEM_READ);
    assign slot_open = !bank_rsp_valid || bank_rsp_ready;

    assign bank_req_ready = !is_read || slot_open;
    assign rd_fire        = bank_req_valid && is_read && slot_open;
    assign wr_fire        = bank_req_valid && !is_read;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < WB; i++) begin
                if (bank_req.byteen[i]) begin
                    mem[word_addr][i*8 +: 8] <= bank_req.data[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_rsp_valid <= 1'b0;
        end else if (slot_open) begin
            bank_rsp_valid <= rd_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            bank_rsp.data <= mem[word_addr];
            bank_rsp.tag  <= bank_req.tag;
            bank_rsp_idx  <= bank_req_idx;
        end
    end

    // No read may overwrite a response the crossbar has not taken yet
    a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
        bank_rsp_valid && !bank_rsp_ready
        |=> bank_rsp_valid && $stable(bank_rsp) && $stable(bank_rsp_idx));

endmodule

`default_nettype wire

/* smem_rsp_xbar.sv */
// Bank responses carry the requester index they return to; order across banks is not kept
`timescale 1ns/1ps
`default_nettype none

module smem_rsp_xbar #(
    parameter int NUM_REQS  = 2,
    parameter int NUM_BANKS = 2
) (
    input  wire logic                                        clk,
    input  wire logic                                        reset,

    input  wire logic [NUM_BANKS-1:0]                        bank_rsp_valid,
    input  wire smem_pkg::smem_rsp_t [NUM_BANKS-1:0]         bank_rsp,
    input  wire logic [NUM_BANKS-1:0][((NUM_REQS > 1) ? $clog2(NUM_REQS) : 1)-1:0] bank_rsp_idx,
    output logic [NUM_BANKS-1:0]                             bank_rsp_ready,

    output logic [NUM_REQS-1:0]                              rsp_valid,
    output smem_pkg::smem_rsp_t [NUM_REQS-1:0]               rsp,
    input  wire logic [NUM_REQS-1:0]                         rsp_ready
);

    localparam int BANK_SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    logic [NUM_REQS-1:0][BANK_SEL_W-1:0] rr_ptr;
    logic [NUM_REQS-1:0][BANK_SEL_W-1:0] win_idx;
    logic [NUM_REQS-1:0]                 win_found;
    logic [NUM_REQS-1:0]                 slot_open;

    assign slot_open = ~rsp_valid | rsp_ready;

    // Per port, pick the next bank holding a response for it
    always_comb begin
        int cand;
        for (int p = 0; p < NUM_REQS; p++) begin
            win_found[p] = 1'b0;
            win_idx[p]   = '0;
            for (int k = 0; k < NUM_BANKS; k++) begin
                cand = (int'(rr_ptr[p]) + k) % NUM_BANKS;
                if (!win_found[p] && bank_rsp_valid[cand]
                        && int'(bank_rsp_idx[cand]) == p) begin
                    win_found[p] = 1'b1;
                    win_idx[p]   = BANK_SEL_W'(cand);
                end
            end
        end
    end

    // Bank is released only by the port slot that takes it
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_rsp_ready[b] = 1'b0;
            for (int p = 0; p < NUM_REQS; p++) begin
                if (win_found[p] && slot_open[p] && int'(win_idx[p]) == b) begin
                    bank_rsp_ready[b] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= '0;
            rr_ptr    <= '0;
        end else begin
            for (int p = 0; p < NUM_REQS; p++) begin
                if (slot_open[p]) begin
                    rsp_valid[p] <= win_found[p];
                    if (win_found[p]) begin
                        rr_ptr[p] <= (int'(win_idx[p]) == NUM_BANKS - 1) ? '0
                                                                        : win_idx[p] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_REQS; p++) begin
            if (slot_open[p] && win_found[p]) begin
                rsp[p] <= bank_rsp[win_idx[p]];
            end
        end
    end

    for (genvar p = 0; p < NUM_REQS; p++) begin : g_chk
        a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
            rsp_valid[p] && !rsp_ready[p] |=> rsp_valid[p] && $stable(rsp[p]));
    end

endmodule

`default_nettype wire

/* smem_perf.sv */
// Counters are 16 bits wide and wrap silently
`timescale 1ns/1ps
`default_nettype none

module smem_perf #(
    parameter int NUM_REQS = 2
) (
    input  wire logic                               clk,
    input  wire logic                               reset,

    input  wire logic [NUM_REQS-1:0]                req_valid,
    input  wire logic [NUM_REQS-1:0]                req_ready,
    input  wire smem_pkg::smem_req_t [NUM_REQS-1:0] req,
    input  wire logic [NUM_REQS-1:0]                rsp_valid,
    input  wire logic [NUM_REQS-1:0]                rsp_ready,

    output smem_pkg::smem_perf_t                    perf
);

    localparam int CW = smem_pkg::CTR_WIDTH;

    logic [CW-1:0] n_reads;
    logic [CW-1:0] n_writes;
    logic [CW-1:0] n_stalls;

    // Population counts of this cycle's events
    always_comb begin
        n_reads  = '0;
        n_writes = '0;
        n_stalls = '0;
        for (int i = 0; i < NUM_REQS; i++) begin
            if (req_valid[i] && req_ready[i]) begin
                if (req[i].op == smem_pkg::SMEM_READ) begin
                    n_reads = n_reads + 1'b1;
                end else begin
                    n_writes = n_writes + 1'b1;
                end
            end
            n_stalls = n_stalls + CW'(rsp_valid[i] && !rsp_ready[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            perf <= '0;
        end else begin
            perf.reads      <= perf.reads + n_reads;
            perf.writes     <= perf.writes + n_writes;
            perf.rsp_stalls <= perf.rsp_stalls + n_stalls;
        end
    end

endmodule

`default_nettype wire

/* smem_top.sv */
// NUM_BANKS must be a power of two; read latency is 3 cycles at best
`timescale 1ns/1ps
`default_nettype none

module smem_top #(
    parameter int NUM_REQS  = 2,
    parameter int NUM_BANKS = 2
) (
    input  wire logic                                clk,
    input  wire logic                                reset,

    input  wire logic [NUM_REQS-1:0]                 req_valid,
    input  wire smem_pkg::smem_req_t [NUM_REQS-1:0]  req,
    output logic [NUM_REQS-1:0]                      req_ready,

    output logic [NUM_REQS-1:0]                      rsp_valid,
    output smem_pkg::smem_rsp_t [NUM_REQS-1:0]       rsp,
    input  wire logic [NUM_REQS-1:0]                 rsp_ready,

    output smem_pkg::smem_perf_t                     perf
);

    localparam int REQ_SEL_W = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1;

    logic [NUM_BANKS-1:0]                 bank_req_valid;
    smem_pkg::smem_req_t [NUM_BANKS-1:0]  bank_req;
    logic [NUM_BANKS-1:0][REQ_SEL_W-1:0]  bank_req_idx;
    logic [NUM_BANKS-1:0]                 bank_req_ready;

    logic [NUM_BANKS-1:0]                 bank_rsp_valid;
    smem_pkg::smem_rsp_t [NUM_BANKS-1:0]  bank_rsp;
    logic [NUM_BANKS-1:0][REQ_SEL_W-1:0]  bank_rsp_idx;
    logic [NUM_BANKS-1:0]                 bank_rsp_ready;

    smem_req_xbar #(
        .NUM_REQS  (NUM_REQS),
        .NUM_BANKS (NUM_BANKS)
    ) u_req_xbar (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req),
        .bank_req_idx   (bank_req_idx),
        .bank_req_ready (bank_req_ready)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        smem_bank #(
            .NUM_REQS  (NUM_REQS),
            .NUM_BANKS (NUM_BANKS)
        ) u_bank (
            .clk            (clk),
            .reset          (reset),
            .bank_req_valid (bank_req_valid[b]),
            .bank_req       (bank_req[b]),
            .bank_req_idx   (bank_req_idx[b]),
            .bank_req_ready (bank_req_ready[b]),
            .bank_rsp_valid (bank_rsp_valid[b]),
            .bank_rsp       (bank_rsp[b]),
            .bank_rsp_idx   (bank_rsp_idx[b]),
            .bank_rsp_ready (bank_rsp_ready[b])
        );
    end

    smem_rsp_xbar #(
        .NUM_REQS  (NUM_REQS),
        .NUM_BANKS (NUM_BANKS)
    ) u_rsp_xbar (
        .clk            (clk),
        .reset          (reset),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .bank_rsp_idx   (bank_rsp_idx),
        .bank_rsp_ready (bank_rsp_ready),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .rsp_ready      (rsp_ready)
    );

    smem_perf #(
        .NUM_REQS (NUM_REQS)
    ) u_perf (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .perf      (perf)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Clock starts low at time zero; reset is released with a nonblocking update on a rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* smem_tb.sv */
// Runs the DUT with 2 ports and 2 banks; all words are written before the first read
`timescale 1ns/1ps
`default_nettype none

module smem_tb;

    localparam int NUM_REQS      = 2;
    localparam int NUM_BANKS     = 2;
    localparam int AW            = smem_pkg::ADDR_WIDTH;
    localparam int NUM_WORDS     = 1 << AW;
    localparam int NUM_TAGS      = 1 << smem_pkg::TAG_WIDTH;
    localparam int FILL_PER_PORT = NUM_WORDS / NUM_REQS;
    localparam int MODE_FILL     = 0;
    localparam int MODE_WR_RD    = 1;
    localparam int MODE_BYTEEN   = 2;
    localparam int MODE_STRESS   = 3;
    localparam int RESET_TIMEOUT = 50;
    localparam int PHASE_TIMEOUT = 20000;
    localparam int DRAIN_TIMEOUT = 2000;

    logic                                clk;
    logic                                reset;
    logic [NUM_REQS-1:0]                 req_valid;
    smem_pkg::smem_req_t [NUM_REQS-1:0]  req;
    logic [NUM_REQS-1:0]                 req_ready;
    logic [NUM_REQS-1:0]                 rsp_valid;
    smem_pkg::smem_rsp_t [NUM_REQS-1:0]  rsp;
    logic [NUM_REQS-1:0]                 rsp_ready;
    smem_pkg::smem_perf_t                perf;

    // Reference memory, and the read scoreboard indexed by tag
    logic [smem_pkg::WORD_WIDTH-1:0] model_mem [NUM_WORDS];
    logic [smem_pkg::WORD_WIDTH-1:0] exp_data [NUM_TAGS];
    logic                            pending [NUM_TAGS];
    int                              owner [NUM_TAGS];

    // Prepared just before each rising edge for the checks on that edge
    logic [NUM_REQS-1:0]                           req_fired;
    logic [NUM_REQS-1:0]                           rsp_known;
    logic [NUM_REQS-1:0][smem_pkg::WORD_WIDTH-1:0] rsp_exp;
    logic [NUM_REQS-1:0]                           hold_nxt;
    logic [NUM_REQS-1:0]                           hold_chk;
    smem_pkg::smem_rsp_t [NUM_REQS-1:0]            hold_rsp_nxt;
    smem_pkg::smem_rsp_t [NUM_REQS-1:0]            hold_rsp_chk;
    smem_pkg::smem_perf_t                          perf_exp;

    logic [31:0] lcg_state;
    int          next_tag;
    int          outstanding;
    int          errors;
    int          total_reads;
    int          total_writes;
    int          total_rsps;
    int          total_stalls;
    string       phase;

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (5)
    ) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    smem_top #(
        .NUM_REQS  (NUM_REQS),
        .NUM_BANKS (NUM_BANKS)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .perf      (perf)
    );

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic logic [31:0] fill_word(input logic [AW-1:0] addr);
        return {addr, 6'h2a, ~addr, 6'h15};
    endfunction

    // A tag is busy while outstanding or waiting on a port
    function automatic logic tag_busy(input int t);
        logic busy;
        busy = pending[t];
        for (int p = 0; p < NUM_REQS; p++) begin
            if (req_valid[p] && req[p].op == smem_pkg::SMEM_READ && int'(req[p].tag) == t) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    function automatic int free_tag();
        int t;
        for (int k = 0; k < NUM_TAGS; k++) begin
            t = (next_tag + k) % NUM_TAGS;
            if (!tag_busy(t)) begin
                next_tag = (t + 1) % NUM_TAGS;
                return t;
            end
        end
        return -1;
    endfunction

    task automatic make_request(input int p, input int mode, input int n, output logic issued);
        smem_pkg::smem_req_t r;
        logic [15:0]         rnd;
        int                  span;
        int                  tag;
        r      = '0;
        issued = 1'b1;
        if (mode == MODE_FILL) begin
            r.op     = smem_pkg::SMEM_WRITE;
            r.addr   = AW'(p * FILL_PER_PORT + n);
            r.byteen = '1;
            r.data   = fill_word(r.addr);
        end else begin
            case (mode)
                MODE_WR_RD:  span = 16;
                MODE_BYTEEN: span = 32;
                default:     span = NUM_WORDS;
            endcase
            rnd      = next_random();
            issued   = (mode != MODE_STRESS) || (rnd[15:14] != 2'b00);
            r.op     = rnd[0] ? smem_pkg::SMEM_WRITE : smem_pkg::SMEM_READ;
            r.addr   = AW'(int'(next_random()) % span);
            r.byteen = (mode == MODE_WR_RD) ? 4'hf : rnd[4:1];
            r.data   = {next_random(), next_random()};
            if (r.op == smem_pkg::SMEM_READ) begin
                tag = free_tag();
                if (tag < 0) begin
                    r.op = smem_pkg::SMEM_WRITE;
                end else begin
                    r.tag = smem_pkg::TAG_WIDTH'(tag);
                end
            end
        end
        req[p]       = r;
        req_valid[p] = issued;
    endtask

    // Offers per_port requests on every port, holding each one until it transfers
    task automatic issue_phase(input string name, input int mode, input int per_port);
        int   sent [NUM_REQS];
        int   cycles;
        logic busy;
        logic issued;
        phase  = name;
        cycles = 0;
        busy   = 1'b1;
        for (int p = 0; p < NUM_REQS; p++) begin
            sent[p] = 0;
        end
        while (busy && cycles < PHASE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            busy = 1'b0;
            for (int p = 0; p < NUM_REQS; p++) begin
                if (req_valid[p] && !req_fired[p]) begin
                    busy = 1'b1;
                end else if (sent[p] < per_port) begin
                    make_request(p, mode, sent[p], issued);
                    sent[p] += int'(issued);
                    busy = 1'b1;
                end else begin
                    req_valid[p] = 1'b0;
                end
                rsp_ready[p] = (mode == MODE_STRESS) ? (next_random() % 8 > 2) : 1'b1;
            end
        end
        if (busy) begin
            errors++;
            $display("Phase %s timed out after %0d cycles with requests not accepted", name, cycles);
        end
    endtask

    task automatic drain_responses();
        int cycles;
        cycles = 0;
        @(negedge clk);
        req_valid = '0;
        rsp_ready = '1;
        while ((outstanding != 0 || rsp_valid != '0) && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (outstanding != 0) begin
            errors++;
            $display("Phase %s left %0d reads without a response", phase, outstanding);
        end
    endtask

    // Samples 1 ns before each rising edge, once inputs and DUT outputs have settled
    always begin : edge_monitor
        int t;
        @(negedge clk);
        #4;
        hold_chk            = hold_nxt;
        hold_rsp_chk        = hold_rsp_nxt;
        perf_exp.reads      = smem_pkg::CTR_WIDTH'(total_reads);
        perf_exp.writes     = smem_pkg::CTR_WIDTH'(total_writes);
        perf_exp.rsp_stalls = smem_pkg::CTR_WIDTH'(total_stalls);
        for (int p = 0; p < NUM_REQS; p++) begin
            rsp_known[p] = 1'b0;
            rsp_exp[p]   = '0;
            hold_nxt[p]  = 1'b0;
            req_fired[p] = 1'b0;
            if (!reset) begin
                if (rsp_valid[p]) begin
                    t               = int'(rsp[p].tag);
                    rsp_known[p]    = pending[t] && owner[t] == p;
                    rsp_exp[p]      = exp_data[t];
                    hold_nxt[p]     = !rsp_ready[p];
                    hold_rsp_nxt[p] = rsp[p];
                    if (!rsp_ready[p]) begin
                        total_stalls++;
                    end else if (rsp_known[p]) begin
                        pending[t] = 1'b0;
                        outstanding--;
                        total_rsps++;
                    end
                end
                req_fired[p] = req_valid[p] && req_ready[p];
                if (req_fired[p] && req[p].op == smem_pkg::SMEM_READ) begin
                    t           = int'(req[p].tag);
                    pending[t]  = 1'b1;
                    owner[t]    = p;
                    exp_data[t] = model_mem[req[p].addr];
                    outstanding++;
                    total_reads++;
                end else if (req_fired[p]) begin
                    for (int i = 0; i < smem_pkg::WORD_BYTES; i++) begin
                        if (req[p].byteen[i]) begin
                            model_mem[req[p].addr][i*8 +: 8] = req[p].data[i*8 +: 8];
                        end
                    end
                    total_writes++;
                end
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) $fell(reset) |-> rsp_valid == '0 && perf == '0)
        else begin
            errors++;
            $display("FAILED reset idle expected 0 actual rsp_valid %h perf %h",
                     $sampled(rsp_valid), $sampled(perf));
        end

    a_perf: assert property (@(posedge clk) disable iff (reset) perf == perf_exp)
        else begin
            errors++;
            $display("FAILED %s perf expected %h actual %h", phase, perf_exp, $sampled(perf));
        end

    for (genvar p = 0; p < NUM_REQS; p++) begin : g_port_chk
        a_rsp_tag: assert property (@(posedge clk) disable iff (reset)
            rsp_valid[p] |-> rsp_known[p])
            else begin
                errors++;
                $display("Port %0d returned tag %h with no matching outstanding read in phase %s",
                         p, $sampled(rsp[p].tag), phase);
            end

        a_rsp_data: assert property (@(posedge clk) disable iff (reset)
            rsp_valid[p] && rsp_known[p] |-> rsp[p].data == rsp_exp[p])
            else begin
                errors++;
                $display("FAILED %s read data port %0d tag %h expected %h actual %h", phase, p,
                         $sampled(rsp[p].tag), rsp_exp[p], $sampled(rsp[p].data));
            end

        a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
            hold_chk[p] |-> rsp_valid[p] && rsp[p] == hold_rsp_chk[p])
            else begin
                errors++;
                $display("FAILED %s held response port %0d expected %h actual %h", phase, p,
                         hold_rsp_chk[p], $sampled(rsp[p]));
            end
    end

    initial begin
        int cycles;
        req_valid    = '0;
        req          = '0;
        rsp_ready    = '1;
        req_fired    = '0;
        rsp_known    = '0;
        rsp_exp      = '0;
        hold_nxt     = '0;
        hold_chk     = '0;
        hold_rsp_nxt = '0;
        hold_rsp_chk = '0;
        perf_exp     = '0;
        lcg_state    = 32'd16621;
        next_tag     = 0;
        outstanding  = 0;
        errors       = 0;
        total_reads  = 0;
        total_writes = 0;
        total_rsps   = 0;
        total_stalls = 0;
        phase        = "reset";
        for (int i = 0; i < NUM_TAGS; i++) begin
            pending[i]  = 1'b0;
            owner[i]    = 0;
            exp_data[i] = '0;
        end
        cycles = 0;
        while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            errors++;
            $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
        end
        @(negedge clk);

        issue_phase("fill", MODE_FILL, FILL_PER_PORT);
        drain_responses();
        issue_phase("write_read", MODE_WR_RD, 400);
        drain_responses();
        issue_phase("byteen", MODE_BYTEEN, 400);
        drain_responses();
        // Random rsp_ready, full address range, both ports colliding on banks
        issue_phase("backpressure", MODE_STRESS, 800);
        drain_responses();

        if (total_rsps != total_reads) begin
            errors++;
            $display("FAILED end response count expected %0d actual %0d", total_reads, total_rsps);
        end
        $display("Summary: %0d reads, %0d writes, %0d responses, %0d stall cycles, %0d errors",
                 total_reads, total_writes, total_rsps, total_stalls, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
smem_pkg.sv
smem_req_xbar.sv
smem_bank.sv
smem_rsp_xbar.sv
smem_perf.sv
smem_top.sv
tb_clock_gen.sv
smem_tb.sv
